/* hdl/mgmt_pkg.sv */
// ##############################
// Management core shared package
// Housekeeping SPI command codes, register map, widths and reset values
// ##############################

package mgmt_pkg;

	// Bus and field widths
	localparam int MPRJ_IO_PADS = 16;
	localparam int MASK_REV_W   = 32;
	localparam int PLL_DIV_W    = 5;
	localparam int HK_ADDR_W    = 8;
	localparam int HK_DATA_W    = 8;

	// Pad bit positions on the management data buses
	localparam int PAD_JTAG = 0;
	localparam int PAD_SDO  = 1;
	localparam int PAD_SDI  = 2;
	localparam int PAD_CSB  = 3;
	localparam int PAD_SCK  = 4;

	// First byte of a housekeeping SPI transaction
	localparam logic [HK_DATA_W-1:0] HK_CMD_WRITE = 8'h80;
	localparam logic [HK_DATA_W-1:0] HK_CMD_READ  = 8'h40;

	// Register map, mask revision is read-only with MSB at the lowest address
	localparam logic [HK_ADDR_W-1:0] HK_ADDR_MASK_REV0 = 8'h00;
	localparam logic [HK_ADDR_W-1:0] HK_ADDR_MASK_REV1 = 8'h01;
	localparam logic [HK_ADDR_W-1:0] HK_ADDR_MASK_REV2 = 8'h02;
	localparam logic [HK_ADDR_W-1:0] HK_ADDR_MASK_REV3 = 8'h03;
	localparam logic [HK_ADDR_W-1:0] HK_ADDR_PLL_CTRL  = 8'h04;
	localparam logic [HK_ADDR_W-1:0] HK_ADDR_PLL_DIV   = 8'h05;
	localparam logic [HK_ADDR_W-1:0] HK_ADDR_PLL_SEL   = 8'h06;
	localparam logic [HK_ADDR_W-1:0] HK_ADDR_OVERRIDE  = 8'h07;
	localparam logic [HK_ADDR_W-1:0] HK_ADDR_IRQ       = 8'h08;
	localparam logic [HK_ADDR_W-1:0] HK_ADDR_EXT_RESET = 8'h09;

	// Register reset values, PLL bypass on after reset
	localparam logic [HK_DATA_W-1:0] PLL_CTRL_RST = 8'h04;
	localparam logic [HK_DATA_W-1:0] PLL_DIV_RST  = 8'h02;
	localparam logic [HK_DATA_W-1:0] PLL_SEL_RST  = 8'h00;

	// SPI slave sequencer states
	localparam int HK_ST_W = 2;
	localparam logic [HK_ST_W-1:0] HK_ST_CMD    = 2'd0;
	localparam logic [HK_ST_W-1:0] HK_ST_ADDR   = 2'd1;
	localparam logic [HK_ST_W-1:0] HK_ST_DATA   = 2'd2;
	localparam logic [HK_ST_W-1:0] HK_ST_IGNORE = 2'd3;

endpackage

/* hdl/hk_spi_slave.sv */
// ##############################
// Housekeeping SPI slave
// Mode 0 byte shifter with command, address and data sequencing
// ##############################
`timescale 1ns/1ps

module hk_spi_slave (
	input  logic                              clock_i,
	input  logic                              arst_n_i,
	input  logic                              hk_connect_i,
	input  logic [mgmt_pkg::MPRJ_IO_PADS-1:0] mgmt_in_data_i,
	input  logic [mgmt_pkg::MPRJ_IO_PADS-1:0] mgmt_out_data_i,
	input  logic [mgmt_pkg::HK_DATA_W-1:0]    reg_rdata_i,
	output logic [mgmt_pkg::HK_ADDR_W-1:0]    reg_addr_o,
	output logic [mgmt_pkg::HK_DATA_W-1:0]    reg_wdata_o,
	output logic                              reg_we_o,
	output logic                              sdo_pre_o,
	output logic                              sdo_enb_o
);
	import mgmt_pkg::*;

	// Raw SPI pins after source selection
	logic spi_sck;
	logic spi_sdi;
	logic spi_csb;

	// Two-flop synchronizers plus SCK edge-detect flop
	logic [1:0] sck_sync;
	logic [1:0] sdi_sync;
	logic [1:0] csb_sync;
	logic       sck_d;
	logic       sck_rise;
	logic       sck_fall;
	logic       sdi_q;
	logic       csb_q;

	// Byte assembly and sequencer state
	logic [$clog2(HK_DATA_W)-1:0] bit_cnt;
	logic [HK_DATA_W-1:0]         rx_sh;
	logic [HK_DATA_W-1:0]         tx_sh;
	logic [HK_ST_W-1:0]           state;
	logic                         byte_done;
	logic                         load_req;
	logic                         is_write;
	logic                         rd_data;

	// Management side drives the slave while hk_connect is set
	assign spi_sck = hk_connect_i ? mgmt_out_data_i[PAD_SCK] : mgmt_in_data_i[PAD_SCK];
	assign spi_sdi = hk_connect_i ? mgmt_out_data_i[PAD_SDI] : mgmt_in_data_i[PAD_SDI];
	assign spi_csb = hk_connect_i ? mgmt_out_data_i[PAD_CSB] : mgmt_in_data_i[PAD_CSB];

	always_ff @(posedge clock_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			sck_sync <= 2'b00;
			sdi_sync <= 2'b00;
			// CSB comes out of reset deselected
			csb_sync <= 2'b11;
			sck_d    <= 1'b0;
		end else begin
			sck_sync <= {sck_sync[0], spi_sck};
			sdi_sync <= {sdi_sync[0], spi_sdi};
			csb_sync <= {csb_sync[0], spi_csb};
			sck_d    <= sck_sync[1];
		end
	end

	assign sck_rise = sck_sync[1] & ~sck_d;
	assign sck_fall = ~sck_sync[1] & sck_d;
	assign sdi_q    = sdi_sync[1];
	assign csb_q    = csb_sync[1];

	// Receive shifter, sampled on SCK rising edges MSB first
	always_ff @(posedge clock_i) begin
		if (sck_rise && !csb_q) begin
			rx_sh <= {rx_sh[HK_DATA_W-2:0], sdi_q};
		end
	end

	// Sequencer
	always_ff @(posedge clock_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state      <= HK_ST_CMD;
			bit_cnt    <= '0;
			byte_done  <= 1'b0;
			load_req   <= 1'b0;
			is_write   <= 1'b0;
			reg_addr_o <= '0;
			tx_sh      <= '0;
		end else if (csb_q) begin
			// Deselect ends the transaction
			state     <= HK_ST_CMD;
			bit_cnt   <= '0;
			byte_done <= 1'b0;
			load_req  <= 1'b0;
		end else begin
			byte_done <= sck_rise && (bit_cnt == ($clog2(HK_DATA_W))'(HK_DATA_W - 1));
			load_req  <= 1'b0;
			if (sck_rise) begin
				bit_cnt <= bit_cnt + 1'b1;
			end

			// Act on a complete byte one cycle after its last edge
			if (byte_done) begin
				case (state)
					HK_ST_CMD: begin
						if (rx_sh == HK_CMD_WRITE) begin
							is_write <= 1'b1;
							state    <= HK_ST_ADDR;
						end else if (rx_sh == HK_CMD_READ) begin
							is_write <= 1'b0;
							state    <= HK_ST_ADDR;
						end else begin
							// Unknown command, drop rest of frame
							state <= HK_ST_IGNORE;
						end
					end
					HK_ST_ADDR: begin
						reg_addr_o <= rx_sh;
						state      <= HK_ST_DATA;
						load_req   <= ~is_write;
					end
					HK_ST_DATA: begin
						// Write strobe uses the old address this cycle
						reg_addr_o <= reg_addr_o + 1'b1;
						load_req   <= ~is_write;
					end
					default: begin
						state <= HK_ST_IGNORE;
					end
				endcase
			end

			// Read data enters after the address settles
			if (load_req) begin
				tx_sh <= reg_rdata_i;
			end else if (sck_fall && (bit_cnt != '0)) begin
				// No shift on the fall after the 8th bit, MSB already waiting
				tx_sh <= {tx_sh[HK_DATA_W-2:0], 1'b0};
			end
		end
	end

	assign rd_data = (state == HK_ST_DATA) && !is_write;

	// Write strobe for each complete data byte
	assign reg_we_o    = byte_done && (state == HK_ST_DATA) && is_write;
	assign reg_wdata_o = rx_sh;

	assign sdo_pre_o = tx_sh[HK_DATA_W-1];
	// Output driver off as soon as CSB is released
	assign sdo_enb_o = spi_csb | ~rd_data;

endmodule

/* hdl/hk_regs.sv */
// ##############################
// Housekeeping register bank
// PLL levels, irq pulse, core reset and pad override
// ##############################
`timescale 1ns/1ps

module hk_regs (
	input  logic                              clock_i,
	input  logic                              arst_n_i,
	input  logic [mgmt_pkg::HK_ADDR_W-1:0]    reg_addr_i,
	input  logic [mgmt_pkg::HK_DATA_W-1:0]    reg_wdata_i,
	input  logic                              reg_we_i,
	output logic [mgmt_pkg::HK_DATA_W-1:0]    reg_rdata_o,
	input  logic [mgmt_pkg::MASK_REV_W-1:0]   mask_rev_i,
	input  logic                              sdo_pre_i,
	input  logic [mgmt_pkg::MPRJ_IO_PADS-1:0] mgmt_out_data_i,
	output logic                              pll_ena_o,
	output logic                              pll_dco_ena_o,
	output logic                              pll_bypass_o,
	output logic [mgmt_pkg::PLL_DIV_W-1:0]    pll_div_o,
	output logic [2:0]                        pll_sel_o,
	output logic [2:0]                        pll90_sel_o,
	output logic                              irq_o,
	output logic                              ext_reset_o,
	output logic                              sdo_o,
	output logic                              jtag_o
);
	import mgmt_pkg::*;

	// Only the implemented field bits are stored
	logic [2:0]           pll_ctrl_q;
	logic [PLL_DIV_W-1:0] pll_div_q;
	logic [5:0]           pll_sel_q;
	logic [1:0]           ovr_q;
	logic                 ext_reset_q;
	logic                 irq_q;

	always_ff @(posedge clock_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pll_ctrl_q  <= PLL_CTRL_RST[2:0];
			pll_div_q   <= PLL_DIV_RST[PLL_DIV_W-1:0];
			pll_sel_q   <= PLL_SEL_RST[5:0];
			ovr_q       <= 2'b00;
			ext_reset_q <= 1'b0;
			irq_q       <= 1'b0;
		end else begin
			// irq is a single-cycle pulse
			irq_q <= 1'b0;
			if (reg_we_i) begin
				case (reg_addr_i)
					HK_ADDR_PLL_CTRL:  pll_ctrl_q  <= reg_wdata_i[2:0];
					HK_ADDR_PLL_DIV:   pll_div_q   <= reg_wdata_i[PLL_DIV_W-1:0];
					HK_ADDR_PLL_SEL:   pll_sel_q   <= reg_wdata_i[5:0];
					HK_ADDR_OVERRIDE:  ovr_q       <= reg_wdata_i[1:0];
					HK_ADDR_IRQ:       irq_q       <= reg_wdata_i[0];
					HK_ADDR_EXT_RESET: ext_reset_q <= reg_wdata_i[0];
					// Read-only and unmapped addresses drop the write
					default: ;
				endcase
			end
		end
	end

	// Read mux, unmapped and IRQ read as zero
	always_comb begin
		reg_rdata_o = '0;
		case (reg_addr_i)
			HK_ADDR_MASK_REV0: reg_rdata_o = mask_rev_i[31:24];
			HK_ADDR_MASK_REV1: reg_rdata_o = mask_rev_i[23:16];
			HK_ADDR_MASK_REV2: reg_rdata_o = mask_rev_i[15:8];
			HK_ADDR_MASK_REV3: reg_rdata_o = mask_rev_i[7:0];
			HK_ADDR_PLL_CTRL:  reg_rdata_o = {5'b0, pll_ctrl_q};
			HK_ADDR_PLL_DIV:   reg_rdata_o = {3'b0, pll_div_q};
			HK_ADDR_PLL_SEL:   reg_rdata_o = {2'b0, pll_sel_q};
			HK_ADDR_OVERRIDE:  reg_rdata_o = {6'b0, ovr_q};
			HK_ADDR_EXT_RESET: reg_rdata_o = {7'b0, ext_reset_q};
			default:           reg_rdata_o = '0;
		endcase
	end

	assign pll_ena_o     = pll_ctrl_q[0];
	assign pll_dco_ena_o = pll_ctrl_q[1];
	assign pll_bypass_o  = pll_ctrl_q[2];
	assign pll_div_o     = pll_div_q;
	assign pll_sel_o     = pll_sel_q[2:0];
	assign pll90_sel_o   = pll_sel_q[5:3];
	assign irq_o         = irq_q;
	assign ext_reset_o   = ext_reset_q;

	// Management data takes over the SDO and JTAG pads when overridden
	assign sdo_o  = ovr_q[0] ? mgmt_out_data_i[PAD_SDO] : sdo_pre_i;
	assign jtag_o = ovr_q[1] ? mgmt_out_data_i[PAD_JTAG] : 1'b0;

endmodule

/* hdl/core_clocking.sv */
// ##############################
// Core clocking
// Core reset synchronizer and divided user-clock tick
// ##############################
`timescale 1ns/1ps

module core_clocking (
	input  logic                           clock_i,
	input  logic                           arst_n_i,
	input  logic                           ext_reset_i,
	input  logic                           pll_ena_i,
	input  logic                           pll_bypass_i,
	input  logic [mgmt_pkg::PLL_DIV_W-1:0] pll_div_i,
	output logic                           core_rstn_o,
	output logic                           user_tick_o
);
	import mgmt_pkg::*;

	logic [1:0]           rst_sync;
	logic [PLL_DIV_W-1:0] div_cnt;
	logic                 tick_q;

	// Asserted at once by arst_n_i, on the next edge by ext_reset
	always_ff @(posedge clock_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			rst_sync <= 2'b00;
		end else if (ext_reset_i) begin
			rst_sync <= 2'b00;
		end else begin
			rst_sync <= {rst_sync[0], 1'b1};
		end
	end

	assign core_rstn_o = rst_sync[1];

	// Down-counter gives one tick every pll_div+1 cycles
	always_ff @(posedge clock_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			div_cnt <= '0;
			tick_q  <= 1'b0;
		end else if (!core_rstn_o || !pll_ena_i || pll_bypass_i) begin
			// Restart the period from a full count
			div_cnt <= pll_div_i;
			tick_q  <= 1'b0;
		end else if (div_cnt == '0) begin
			div_cnt <= pll_div_i;
			tick_q  <= 1'b1;
		end else begin
			div_cnt <= div_cnt - 1'b1;
			tick_q  <= 1'b0;
		end
	end

	// Bypass runs the user side at the full clock rate
	assign user_tick_o = pll_bypass_i | tick_q;

endmodule

/* hdl/mgmt_core.sv */
// ##############################
// Management core top
// Housekeeping SPI, register bank and clocking
// ##############################
`timescale 1ns/1ps

module mgmt_core (
	input  logic                              clock_i,
	input  logic                              arst_n_i,
	input  logic                              hk_connect_i,
	input  logic [mgmt_pkg::MPRJ_IO_PADS-1:0] mgmt_in_data_i,
	input  logic [mgmt_pkg::MPRJ_IO_PADS-1:0] mgmt_out_data_i,
	input  logic [mgmt_pkg::MASK_REV_W-1:0]   mask_rev_i,
	output logic                              sdo_o,
	output logic                              sdo_enb_o,
	output logic                              jtag_o,
	output logic                              pll_ena_o,
	output logic                              pll_dco_ena_o,
	output logic                              pll_bypass_o,
	output logic [mgmt_pkg::PLL_DIV_W-1:0]    pll_div_o,
	output logic [2:0]                        pll_sel_o,
	output logic [2:0]                        pll90_sel_o,
	output logic                              irq_o,
	output logic                              core_rstn_o,
	output logic                              user_tick_o
);
	import mgmt_pkg::*;

	// Register access from the SPI slave
	logic [HK_ADDR_W-1:0] reg_addr;
	logic [HK_DATA_W-1:0] reg_wdata;
	logic [HK_DATA_W-1:0] reg_rdata;
	logic                 reg_we;
	logic                 sdo_pre;
	logic                 ext_reset;

	hk_spi_slave u_hk_spi_slave (
		.clock_i         (clock_i),
		.arst_n_i        (arst_n_i),
		.hk_connect_i    (hk_connect_i),
		.mgmt_in_data_i  (mgmt_in_data_i),
		.mgmt_out_data_i (mgmt_out_data_i),
		.reg_rdata_i     (reg_rdata),
		.reg_addr_o      (reg_addr),
		.reg_wdata_o     (reg_wdata),
		.reg_we_o        (reg_we),
		.sdo_pre_o       (sdo_pre),
		.sdo_enb_o       (sdo_enb_o)
	);

	hk_regs u_hk_regs (
		.clock_i         (clock_i),
		.arst_n_i        (arst_n_i),
		.reg_addr_i      (reg_addr),
		.reg_wdata_i     (reg_wdata),
		.reg_we_i        (reg_we),
		.reg_rdata_o     (reg_rdata),
		.mask_rev_i      (mask_rev_i),
		.sdo_pre_i       (sdo_pre),
		.mgmt_out_data_i (mgmt_out_data_i),
		.pll_ena_o       (pll_ena_o),
		.pll_dco_ena_o   (pll_dco_ena_o),
		.pll_bypass_o    (pll_bypass_o),
		.pll_div_o       (pll_div_o),
		.pll_sel_o       (pll_sel_o),
		.pll90_sel_o     (pll90_sel_o),
		.irq_o           (irq_o),
		.ext_reset_o     (ext_reset),
		.sdo_o           (sdo_o),
		.jtag_o          (jtag_o)
	);

	// PLL levels stand in for the analog PLL controls
	core_clocking u_core_clocking (
		.clock_i      (clock_i),
		.arst_n_i     (arst_n_i),
		.ext_reset_i  (ext_reset),
		.pll_ena_i    (pll_ena_o),
		.pll_bypass_i (pll_bypass_o),
		.pll_div_i    (pll_div_o),
		.core_rstn_o  (core_rstn_o),
		.user_tick_o  (user_tick_o)
	);

endmodule

/* testbench/mgmt_core_props.sv */
// ##############################
// Management core assertions
// irq pulse width, SDO enable and core reset hold
// ##############################
`timescale 1ns/1ps

module mgmt_core_props (
	input  logic                              clock_i,
	input  logic                              arst_n_i,
	input  logic                              hk_connect_i,
	input  logic [mgmt_pkg::MPRJ_IO_PADS-1:0] mgmt_in_data_i,
	input  logic [mgmt_pkg::MPRJ_IO_PADS-1:0] mgmt_out_data_i,
	input  logic                              sdo_enb_i,
	input  logic                              irq_i,
	input  logic                              core_rstn_i,
	input  logic                              ext_reset_i
);
	import mgmt_pkg::*;

	// CSB as the slave selects it
	logic csb;

	assign csb = hk_connect_i ? mgmt_out_data_i[PAD_CSB] : mgmt_in_data_i[PAD_CSB];

	// irq is a single-cycle pulse
	a_irq_single: assert property (@(posedge clock_i) disable iff (!arst_n_i)
		irq_i |=> !irq_i)
		else $error("irq_o stayed high for two cycles");

	// SDO driver stays off outside a transaction and as the next one opens
	a_sdo_idle: assert property (@(posedge clock_i) disable iff (!arst_n_i)
		(csb || $fell(csb)) |-> sdo_enb_i)
		else $error("sdo_enb_o low while CSB is high or just selected");

	// Core held in reset one edge after ext_reset is seen
	a_core_rst: assert property (@(posedge clock_i) disable iff (!arst_n_i)
		ext_reset_i |=> !core_rstn_i)
		else $error("core_rstn_o high while ext_reset is set");

endmodule

bind mgmt_core mgmt_core_props u_props (
	.clock_i         (clock_i),
	.arst_n_i        (arst_n_i),
	.hk_connect_i    (hk_connect_i),
	.mgmt_in_data_i  (mgmt_in_data_i),
	.mgmt_out_data_i (mgmt_out_data_i),
	.sdo_enb_i       (sdo_enb_o),
	.irq_i           (irq_o),
	.core_rstn_i     (core_rstn_o),
	.ext_reset_i     (ext_reset)
);

/* testbench/tb_mgmt_core.sv */
// ##############################
// Management core testbench
// Directed SPI host tests for registers, clocking and pad override
// ##############################
`timescale 1ns/1ps

module tb_mgmt_core;
	import mgmt_pkg::*;

	// Clock cycles per SCK phase and settle time after CSB release
	localparam int SCK_HALF  = 4;
	localparam int HK_SETTLE = 4;

	logic                    clock;
	logic                    arst_n;
	logic                    hk_connect;
	logic [MPRJ_IO_PADS-1:0] mgmt_in_data;
	logic [MPRJ_IO_PADS-1:0] mgmt_out_data;
	logic [MASK_REV_W-1:0]   mask_rev;
	logic                    sdo;
	logic                    sdo_enb;
	logic                    jtag;
	logic                    pll_ena;
	logic                    pll_dco_ena;
	logic                    pll_bypass;
	logic [PLL_DIV_W-1:0]    pll_div;
	logic [2:0]              pll_sel;
	logic [2:0]              pll90_sel;
	logic                    irq;
	logic                    core_rstn;
	logic                    user_tick;

	// Data bytes of the current SPI transaction
	logic [7:0] xfer_buf [0:7];
	integer     seed;
	int         irq_cnt;

	mgmt_core dut0 (
		.clock_i         (clock),
		.arst_n_i        (arst_n),
		.hk_connect_i    (hk_connect),
		.mgmt_in_data_i  (mgmt_in_data),
		.mgmt_out_data_i (mgmt_out_data),
		.mask_rev_i      (mask_rev),
		.sdo_o           (sdo),
		.sdo_enb_o       (sdo_enb),
		.jtag_o          (jtag),
		.pll_ena_o       (pll_ena),
		.pll_dco_ena_o   (pll_dco_ena),
		.pll_bypass_o    (pll_bypass),
		.pll_div_o       (pll_div),
		.pll_sel_o       (pll_sel),
		.pll90_sel_o     (pll90_sel),
		.irq_o           (irq),
		.core_rstn_o     (core_rstn),
		.user_tick_o     (user_tick)
	);

	always #2 clock = ~clock;

	// Counts every cycle with irq high
	always begin
		@(posedge clock);
		#1;
		if (irq) begin
			irq_cnt++;
		end
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("*** FAILED ***");
		$fatal(1, "Simulation stopped on error");
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			abort_run($sformatf("ERROR at %0t ns: %s = 0x%0h, expected 0x%0h",
				$time, name, got, exp));
		end
	endtask

	// Inputs change 1 ns after the rising edge
	task automatic step(input int n);
		repeat (n) begin
			@(posedge clock);
			#1;
		end
	endtask

	// SPI pins live on the management bus while hk_connect is set
	task automatic drive_spi_pins(input logic sck, input logic sdi, input logic csb);
		if (hk_connect) begin
			mgmt_out_data[PAD_SCK] = sck;
			mgmt_out_data[PAD_SDI] = sdi;
			mgmt_out_data[PAD_CSB] = csb;
		end else begin
			mgmt_in_data[PAD_SCK] = sck;
			mgmt_in_data[PAD_SDI] = sdi;
			mgmt_in_data[PAD_CSB] = csb;
		end
	endtask

	// Mode 0, SDO sampled at the end of each low phase
	task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
		int i;
		for (i = 7; i >= 0; i--) begin
			drive_spi_pins(1'b0, tx[i], 1'b0);
			step(SCK_HALF);
			rx[i] = sdo;
			drive_spi_pins(1'b1, tx[i], 1'b0);
			step(SCK_HALF);
		end
	endtask

	task automatic spi_start();
		drive_spi_pins(1'b0, 1'b0, 1'b0);
		step(SCK_HALF);
	endtask

	task automatic spi_stop();
		drive_spi_pins(1'b0, 1'b0, 1'b0);
		step(SCK_HALF);
		drive_spi_pins(1'b0, 1'b0, 1'b1);
		step(HK_SETTLE);
	endtask

	task automatic spi_write(input logic [7:0] addr, input int n);
		logic [7:0] rx;
		int         i;
		spi_start();
		spi_byte(HK_CMD_WRITE, rx);
		spi_byte(addr, rx);
		for (i = 0; i < n; i++) begin
			spi_byte(xfer_buf[i], rx);
		end
		spi_stop();
	endtask

	task automatic spi_read(input logic [7:0] addr, input int n);
		logic [7:0] rx;
		int         i;
		spi_start();
		spi_byte(HK_CMD_READ, rx);
		spi_byte(addr, rx);
		for (i = 0; i < n; i++) begin
			spi_byte(8'h00, rx);
			xfer_buf[i] = rx;
			// Slave drives SDO through the read data bytes
			check("sdo_enb_o", sdo_enb, 0);
		end
		spi_stop();
	endtask

	task automatic wait_core_rstn(input logic level, input int max_cycles);
		int n;
		n = 0;
		while (core_rstn !== level && n < max_cycles) begin
			step(1);
			n++;
		end
		if (core_rstn !== level) begin
			abort_run($sformatf("Timeout: core reset output did not reach %0b in %0d cycles",
				level, max_cycles));
		end
	endtask

	task automatic count_ticks(input int cycles, output int cnt);
		cnt = 0;
		repeat (cycles) begin
			step(1);
			if (user_tick) begin
				cnt++;
			end
		end
	endtask

	task automatic test_reset_defaults();
		check("pll_bypass_o", pll_bypass, 1);
		check("pll_div_o", pll_div, 2);
		check("pll_ena_o", pll_ena, 0);
		check("irq_o", irq, 0);
		check("sdo_enb_o", sdo_enb, 1);
		check("jtag_o", jtag, 0);
		wait_core_rstn(1'b1, 10);
		// Bypass runs the tick at the full clock rate
		repeat (8) begin
			step(1);
			check("user_tick_o", user_tick, 1);
		end
	endtask

	task automatic test_write_read();
		logic [7:0] ctrl;
		logic [7:0] div;
		logic [7:0] sel;
		ctrl = $random(seed) & 8'h07;
		div  = $random(seed) & 8'h1f;
		sel  = $random(seed) & 8'h3f;
		xfer_buf[0] = ctrl;
		xfer_buf[1] = div;
		xfer_buf[2] = sel;
		spi_write(HK_ADDR_PLL_CTRL, 3);
		check("pll_ena_o", pll_ena, ctrl[0]);
		check("pll_dco_ena_o", pll_dco_ena, ctrl[1]);
		check("pll_bypass_o", pll_bypass, ctrl[2]);
		check("pll_div_o", pll_div, div[4:0]);
		check("pll_sel_o", pll_sel, sel[2:0]);
		check("pll90_sel_o", pll90_sel, sel[5:3]);
		spi_read(HK_ADDR_PLL_CTRL, 3);
		check("PLL_CTRL read", xfer_buf[0], ctrl);
		check("PLL_DIV read", xfer_buf[1], div);
		check("PLL_SEL read", xfer_buf[2], sel);
		// MSB of mask_rev at the lowest address
		spi_read(HK_ADDR_MASK_REV0, 4);
		check("MASK_REV0 read", xfer_buf[0], mask_rev[31:24]);
		check("MASK_REV1 read", xfer_buf[1], mask_rev[23:16]);
		check("MASK_REV2 read", xfer_buf[2], mask_rev[15:8]);
		check("MASK_REV3 read", xfer_buf[3], mask_rev[7:0]);
		spi_read(8'h3c, 1);
		check("unmapped read", xfer_buf[0], 8'h00);
	endtask

	task automatic test_divided_tick();
		int cnt;
		// Divide by 3+1 loaded while bypass holds the counter at a full count
		xfer_buf[0] = 8'h04;
		xfer_buf[1] = 8'h03;
		spi_write(HK_ADDR_PLL_CTRL, 2);
		// Bypass off, enable on
		xfer_buf[0] = 8'h01;
		spi_write(HK_ADDR_PLL_CTRL, 1);
		check("pll_bypass_o", pll_bypass, 0);
		check("pll_ena_o", pll_ena, 1);
		check("pll_div_o", pll_div, 3);
		count_ticks(40, cnt);
		// Window is a whole number of periods
		check("user_tick_o count", cnt, 40 / (3 + 1));
		xfer_buf[0] = 8'h00;
		spi_write(HK_ADDR_PLL_CTRL, 1);
		count_ticks(40, cnt);
		check("user_tick_o count, disabled", cnt, 0);
	endtask

	task automatic test_irq_ext_reset();
		int irq_base;
		irq_base = irq_cnt;
		xfer_buf[0] = 8'h01;
		spi_write(HK_ADDR_IRQ, 1);
		step(4);
		check("irq_o cycles", irq_cnt - irq_base, 1);
		check("irq_o", irq, 0);
		spi_write(HK_ADDR_EXT_RESET, 1);
		// Settle time after CSB release has already passed
		check("core_rstn_o", core_rstn, 0);
		// Held while the register stays set
		repeat (20) begin
			step(1);
			check("core_rstn_o", core_rstn, 0);
		end
		xfer_buf[0] = 8'h00;
		spi_write(HK_ADDR_EXT_RESET, 1);
		wait_core_rstn(1'b1, 8);
	endtask

	task automatic test_pad_override();
		logic [31:0] r;
		logic [7:0]  sel;
		// Overrides off, management bits must not reach the pads
		mgmt_out_data[PAD_JTAG] = 1'b1;
		mgmt_out_data[PAD_SDO]  = 1'b1;
		step(1);
		check("jtag_o", jtag, 0);
		spi_read(HK_ADDR_PLL_DIV, 1);
		check("PLL_DIV read, no override", xfer_buf[0], 8'h03);
		xfer_buf[0] = 8'h03;
		spi_write(HK_ADDR_OVERRIDE, 1);
		repeat (8) begin
			r = $random(seed);
			mgmt_out_data[PAD_JTAG] = r[0];
			mgmt_out_data[PAD_SDO]  = r[1];
			step(1);
			check("jtag_o", jtag, r[0]);
			check("sdo_o", sdo, r[1]);
		end
		xfer_buf[0] = 8'h00;
		spi_write(HK_ADDR_OVERRIDE, 1);
		mgmt_out_data[PAD_JTAG] = 1'b0;
		mgmt_out_data[PAD_SDO]  = 1'b0;
		step(2);
		// Host moves over to the management SPI pins
		hk_connect = 1'b1;
		step(2);
		sel = $random(seed) & 8'h3f;
		xfer_buf[0] = sel;
		spi_write(HK_ADDR_PLL_SEL, 1);
		check("pll_sel_o", pll_sel, sel[2:0]);
		check("pll90_sel_o", pll90_sel, sel[5:3]);
		spi_read(HK_ADDR_PLL_SEL, 1);
		check("PLL_SEL read, hk_connect", xfer_buf[0], sel);
		hk_connect = 1'b0;
		step(2);
	endtask

	initial begin
		seed          = 65845;
		irq_cnt       = 0;
		clock         = 1'b0;
		arst_n        = 1'b0;
		hk_connect    = 1'b0;
		// CSB idles high on both SPI sources
		mgmt_in_data  = '0;
		mgmt_out_data = '0;
		mgmt_in_data[PAD_CSB]  = 1'b1;
		mgmt_out_data[PAD_CSB] = 1'b1;
		mask_rev      = $random(seed);
		step(5);
		arst_n = 1'b1;
		test_reset_defaults();
		test_write_read();
		test_divided_tick();
		test_irq_ext_reset();
		test_pad_override();
		$display("*** PASSED ***");
		$finish;
	end

endmodule

/* sim.f */
hdl/mgmt_pkg.sv
hdl/hk_spi_slave.sv
hdl/hk_regs.sv
hdl/core_clocking.sv
hdl/mgmt_core.sv
testbench/mgmt_core_props.sv
testbench/tb_mgmt_core.sv

/* run_sim.sh */
#!/bin/sh
# Build the management core testbench with Verilator, run it, check the log
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_mgmt_core \
	> build.log 2>&1 \
	&& ./obj_dir/Vtb_mgmt_core > sim.log 2>&1 \
	&& grep -q "^\*\*\* PASSED \*\*\*$" sim.log \
	&& echo "Simulation passed, see sim.log" \
	|| { echo "Simulation failed, see build.log and sim.log"; exit 1; }
